// File: Bender.yml
package:
  name: wvf_acq

sources:
  - design/wvf_pkg.sv
  - design/trig_capture.sv
  - design/wvf_buffer.sv
  - design/rdout_framer.sv
  - design/wvf_acq_top.sv
  - target: test
    files:
      - dv/wvf_acq_chk.sv
      - dv/tb_wvf_acq.sv

// File: design/rdout_framer.sv
// readout framer, consumer side of the waveform buffer
// one-word valid/ready output register, waveform boundary tracking
`default_nettype none

module rdout_framer
  import wvf_pkg::*;
(
  input  logic              lclk,
  input  logic              lclk_rst,

  // show-ahead buffer side
  input  logic              i_not_empty,
  input  rdout_word_u       i_head_word,
  output logic              o_pop,

  // word stream out
  input  logic              i_rdout_ready,
  output logic              o_rdout_valid,
  output logic [WORD_W-1:0] o_rdout_word,
  output logic              o_rdout_last
);

  logic              out_valid;
  logic [WORD_W-1:0] out_word;
  logic              out_last;
  // sample words still due in the current waveform
  logic [LEN_W-1:0]  samp_left;
  logic              drain;

  // output register empties on a transfer
  assign drain = out_valid && i_rdout_ready;

  // refill when empty or draining
  assign o_pop = i_not_empty && (!out_valid || i_rdout_ready);

  // control state of the output register
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      out_valid <= 1'b0;
      out_last <= 1'b0;
      samp_left <= '0;
    end else begin
      if (o_pop) begin
        out_valid <= 1'b1;
        if (i_head_word.hdr.kind) begin
          // header starts a new waveform
          samp_left <= i_head_word.hdr.n_samp;
          out_last <= 1'b0;
        end else begin
          // sample, last when the countdown hits its end
          samp_left <= samp_left - 1'b1;
          out_last <= (samp_left == LEN_W'(1));
        end
      end else if (drain) begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
      end
    end
  end

  // payload, held while stalled
  always_ff @(posedge lclk) begin
    if (o_pop) begin
      out_word <= i_head_word;
    end
  end

  assign o_rdout_valid = out_valid;
  assign o_rdout_word = out_word;
  assign o_rdout_last = out_last;

endmodule

`default_nettype wire

// File: design/trig_capture.sv
// capture stage, producer side of the waveform buffer
// time counter, threshold/software trigger, pre-trigger delay line,
// capture sequencing and credit tracking
`default_nettype none

module trig_capture
  import wvf_pkg::*;
(
  input  logic                  lclk,
  input  logic                  lclk_rst,

  // adc stream and trigger config
  input  logic [ADC_W-1:0]      i_adc_sample,
  input  logic [ADC_W-1:0]      i_thresh,
  input  logic                  i_trig_en,
  input  logic                  i_sw_trig,
  input  logic [POST_LEN_W-1:0] i_post_len,

  // one pulse per word popped from the buffer
  input  logic                  i_credit_return,

  // buffer write side
  output logic                  o_wr_en,
  output rdout_word_u           o_wr_word
);

  logic [LTC_W-1:0]    ltc;
  // dly_line[k] holds the sample of time t-1-k
  logic [ADC_W-1:0]    dly_line [PRE_LEN+1];
  logic                thresh_hit;
  logic                trig_fire;
  logic                trig_accept;
  logic [CREDIT_W-1:0] credit_cnt;
  logic [CREDIT_W-1:0] credit_need;
  logic                capt_busy;
  logic [LEN_W-1:0]    words_left;
  rdout_word_u         hdr_word;
  rdout_word_u         samp_word;

  // free-running local time, 0 in the first cycle out of reset
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      ltc <= '0;
    end else begin
      ltc <= ltc + 1'b1;
    end
  end

  // sample history, zeros stand in for samples before time 0
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      for (int i = 0; i <= PRE_LEN; i++) begin
        dly_line[i] <= '0;
      end
    end else begin
      dly_line[0] <= i_adc_sample;
      for (int i = 1; i <= PRE_LEN; i++) begin
        dly_line[i] <= dly_line[i-1];
      end
    end
  end

  // rising crossing, dly_line[0] is the previous sample
  assign thresh_hit = i_trig_en &&
                      (i_adc_sample >= i_thresh) &&
                      (dly_line[0] < i_thresh);
  assign trig_fire = thresh_hit || i_sw_trig;

  // header plus pre and post samples
  assign credit_need = CREDIT_W'(PRE_LEN + 1) + CREDIT_W'(i_post_len);

  // idle also excludes the cycle that carries the last sample write
  assign trig_accept = trig_fire && !capt_busy && !o_wr_en &&
                       (credit_cnt >= credit_need);

  // header for a trigger in this cycle
  // software wins when both fire
  always_comb begin
    hdr_word = '0;
    hdr_word.hdr.kind = 1'b1;
    hdr_word.hdr.sw_src = i_sw_trig;
    hdr_word.hdr.n_samp = LEN_W'(PRE_LEN) + LEN_W'(i_post_len);
    hdr_word.hdr.trig_time = ltc[23:0];
  end

  // oldest delay tap lines up with the registered write
  always_comb begin
    samp_word = '0;
    samp_word.samp.kind = 1'b0;
    samp_word.samp.sample = dly_line[PRE_LEN];
  end

  // capture FSM: idle, then one sample word per cycle
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      capt_busy <= 1'b0;
      words_left <= '0;
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;
      if (capt_busy) begin
        o_wr_en <= 1'b1;
        words_left <= words_left - 1'b1;
        // final sample registered this cycle
        if (words_left == LEN_W'(1)) begin
          capt_busy <= 1'b0;
        end
      end else if (trig_accept) begin
        o_wr_en <= 1'b1;
        capt_busy <= 1'b1;
        words_left <= hdr_word.hdr.n_samp;
      end
    end
  end

  // write payload
  always_ff @(posedge lclk) begin
    if (capt_busy) begin
      o_wr_word <= samp_word;
    end else if (trig_accept) begin
      o_wr_word <= hdr_word;
    end
  end

  // credits: up on return, down on each write
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      credit_cnt <= CREDIT_W'(BUF_DEPTH);
    end else begin
      credit_cnt <= credit_cnt + CREDIT_W'(i_credit_return) - CREDIT_W'(o_wr_en);
    end
  end

endmodule

`default_nettype wire

// File: design/wvf_acq_top.sv
// top level of the single-channel acquisition path
// capture stage -> waveform buffer -> readout framer
`default_nettype none

module wvf_acq_top
  import wvf_pkg::*;
(
  input  logic                  lclk,
  input  logic                  lclk_rst,

  // adc stream
  input  logic [ADC_W-1:0]      i_adc_sample,

  // trigger and window config
  input  logic [ADC_W-1:0]      i_thresh,
  input  logic                  i_trig_en,
  input  logic                  i_sw_trig,
  input  logic [POST_LEN_W-1:0] i_post_len,

  // readout stream
  input  logic                  i_rdout_ready,
  output logic                  o_rdout_valid,
  output logic [WORD_W-1:0]     o_rdout_word,
  output logic                  o_rdout_last
);

  // capture -> buffer, credits back
  logic        wr_en;
  rdout_word_u wr_word;
  logic        credit_return;

  // buffer -> framer
  logic        not_empty;
  rdout_word_u head_word;
  logic        pop;

  trig_capture u_capture (
    .lclk            (lclk),
    .lclk_rst        (lclk_rst),
    .i_adc_sample    (i_adc_sample),
    .i_thresh        (i_thresh),
    .i_trig_en       (i_trig_en),
    .i_sw_trig       (i_sw_trig),
    .i_post_len      (i_post_len),
    .i_credit_return (credit_return),
    .o_wr_en         (wr_en),
    .o_wr_word       (wr_word)
  );

  wvf_buffer u_buffer (
    .lclk            (lclk),
    .lclk_rst        (lclk_rst),
    .i_wr_en         (wr_en),
    .i_wr_word       (wr_word),
    .i_pop           (pop),
    .o_not_empty     (not_empty),
    .o_head_word     (head_word),
    .o_credit_return (credit_return)
  );

  rdout_framer u_framer (
    .lclk          (lclk),
    .lclk_rst      (lclk_rst),
    .i_not_empty   (not_empty),
    .i_head_word   (head_word),
    .o_pop         (pop),
    .i_rdout_ready (i_rdout_ready),
    .o_rdout_valid (o_rdout_valid),
    .o_rdout_word  (o_rdout_word),
    .o_rdout_last  (o_rdout_last)
  );

endmodule

`default_nettype wire

// File: design/wvf_buffer.sv
// waveform buffer, word FIFO between capture and readout
// show-ahead head word, one credit returned per pop
`default_nettype none

module wvf_buffer
  import wvf_pkg::*;
(
  input  logic        lclk,
  input  logic        lclk_rst,

  // write side from the capture stage
  input  logic        i_wr_en,
  input  rdout_word_u i_wr_word,

  // show-ahead read side
  input  logic        i_pop,
  output logic        o_not_empty,
  output rdout_word_u o_head_word,

  // credit pulse back to the producer
  output logic        o_credit_return
);

  rdout_word_u                  mem [BUF_DEPTH];
  logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
  logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
  // one extra bit to tell full from empty
  logic [$clog2(BUF_DEPTH):0]   fill_cnt;

  // storage
  always_ff @(posedge lclk) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_wr_word;
    end
  end

  // pointers and fill level
  // producer credits keep writes off a full buffer
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill_cnt <= '0;
    end else begin
      if (i_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill_cnt <= fill_cnt + ($clog2(BUF_DEPTH)+1)'(i_wr_en)
                           - ($clog2(BUF_DEPTH)+1)'(i_pop);
    end
  end

  // head visible the cycle after its write
  assign o_not_empty = (fill_cnt != '0);
  assign o_head_word = mem[rd_ptr];

  // one credit per popped word, a cycle late
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_credit_return <= 1'b0;
    end else begin
      o_credit_return <= i_pop;
    end
  end

endmodule

`default_nettype wire

// File: design/wvf_pkg.sv
// shared widths and sizes for the single-channel acquisition path
// readout word union, decoded as header or sample
`default_nettype none

package wvf_pkg;

  // adc sample width
  localparam int ADC_W = 12;
  // local time counter width
  localparam int LTC_W = 24;

  // samples kept ahead of the trigger
  localparam int PRE_LEN = 4;
  // post length setting, legal 1..31
  localparam int POST_LEN_W = 5;
  // sample count field in the header
  localparam int LEN_W = 6;

  // readout stream word
  localparam int WORD_W = 32;

  // waveform buffer entries, also the initial credit count
  localparam int BUF_DEPTH = 64;
  // credit counter must hold BUF_DEPTH itself
  localparam int CREDIT_W = 7;

  // one buffer/readout word
  // kind bit is shared by both views, 1 = header, 0 = sample
  typedef union packed {
    struct packed {
      logic              kind;
      // 1 = software trigger
      logic              sw_src;
      // pre + post sample words that follow
      logic [LEN_W-1:0]  n_samp;
      // low bits of the trigger time
      logic [23:0]       trig_time;
    } hdr;
    struct packed {
      logic              kind;
      logic [18:0]       rsvd;
      logic [ADC_W-1:0]  sample;
    } samp;
  } rdout_word_u;

endpackage

`default_nettype wire

// File: dv/tb_wvf_acq.sv
// testbench for the single-channel acquisition path
// random walk stimulus, per-time sample log, waveform model,
// readout stream checks and cycle timeout
`default_nettype none

module tb_wvf_acq
  import wvf_pkg::*;
();

  logic                  lclk = 1'b0;
  logic                  lclk_rst;
  logic [ADC_W-1:0]      i_adc_sample;
  logic [ADC_W-1:0]      i_thresh;
  logic                  i_trig_en;
  logic                  i_sw_trig;
  logic [POST_LEN_W-1:0] i_post_len;
  logic                  i_rdout_ready;
  logic                  o_rdout_valid;
  logic [WORD_W-1:0]     o_rdout_word;
  logic                  o_rdout_last;

  // per-time log indexed by local time
  logic [ADC_W-1:0] samp_log [$];
  bit               fire_log [$];
  bit               sw_log [$];
  bit               exact_log [$];
  int               plen_log [$];
  // trigger times the model expects while ready is held high
  int               pred_q [$];
  logic             exact_mode;
  int               t_now = 0;
  int               pred_next = 0;
  int               obs_next = 0;
  // waveform being received
  bit               in_wvf = 0;
  int               cur_n;
  int               cur_idx;
  int               cur_len;
  // stall tracking
  bit               stalled = 0;
  logic [WORD_W-1:0] held_word;
  logic             held_last;
  int               quiet_cnt = 0;
  int               cycle_cnt = 0;
  int               timeout_cyc;
  int               n_sw = 0;
  int               n_thr = 0;
  int               walk;
  // ready high x2, random ready, stall, resume
  int               phase_len [5] = '{300, 150, 400, 300, 300};
  int               gap_len = 40;

  always #20 lclk = ~lclk;

  wvf_acq_top uut (
    .lclk          (lclk),
    .lclk_rst      (lclk_rst),
    .i_adc_sample  (i_adc_sample),
    .i_thresh      (i_thresh),
    .i_trig_en     (i_trig_en),
    .i_sw_trig     (i_sw_trig),
    .i_post_len    (i_post_len),
    .i_rdout_ready (i_rdout_ready),
    .o_rdout_valid (o_rdout_valid),
    .o_rdout_word  (o_rdout_word),
    .o_rdout_last  (o_rdout_last)
  );

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(string name, logic [WORD_W-1:0] got, logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s got 0x%0h expected 0x%0h at time %0d",
                         name, got, exp, t_now));
    end
  endtask

  // samples before time 0 count as zero
  function automatic logic [ADC_W-1:0] samp_at(int t);
    if (t < 0) begin
      return '0;
    end
    return samp_log[t];
  endfunction

  // header fields from the logged trigger of time n
  function automatic logic [WORD_W-1:0] exp_header(int n);
    return {1'b1, sw_log[n], LEN_W'(PRE_LEN + plen_log[n]), 24'(n)};
  endfunction

  // trigger rule and accepted windows for the cycle that just closed
  task automatic log_cycle();
    bit thr;
    bit fire;
    thr = i_trig_en && (i_adc_sample >= i_thresh) && (samp_at(t_now - 1) < i_thresh);
    fire = thr || i_sw_trig;
    samp_log.push_back(i_adc_sample);
    fire_log.push_back(fire);
    sw_log.push_back(i_sw_trig);
    plen_log.push_back(int'(i_post_len));
    exact_log.push_back(exact_mode);
    // next window may open the cycle after the last sample write
    if (exact_mode && fire && t_now >= pred_next) begin
      pred_q.push_back(t_now);
      pred_next = t_now + PRE_LEN + int'(i_post_len) + 2;
    end
  endtask

  task automatic watch_output();
    rdout_word_u w;
    int          n;
    if (stalled) begin
      check_val("o_rdout_valid", o_rdout_valid, 1'b1);
      check_val("o_rdout_word", o_rdout_word, held_word);
      check_val("o_rdout_last", o_rdout_last, held_last);
    end
    stalled = o_rdout_valid && !i_rdout_ready;
    held_word = o_rdout_word;
    held_last = o_rdout_last;
    quiet_cnt = o_rdout_valid ? 0 : quiet_cnt + 1;
    if (!(o_rdout_valid && i_rdout_ready)) begin
      return;
    end
    w = o_rdout_word;
    if (!in_wvf) begin
      if (!w.hdr.kind) begin
        fail_run($sformatf("sample word outside a waveform at time %0d", t_now));
      end
      n = int'(w.hdr.trig_time);
      if (n >= fire_log.size() || !fire_log[n]) begin
        fail_run($sformatf("header time %0d does not meet the trigger rule", n));
      end
      if (n < obs_next) begin
        fail_run($sformatf("waveform at time %0d overlaps the one before", n));
      end
      if (exact_log[n]) begin
        if (pred_q.size() == 0) begin
          fail_run($sformatf("waveform at time %0d was not predicted", n));
        end
        check_val("o_rdout_word", o_rdout_word, exp_header(pred_q.pop_front()));
      end else begin
        check_val("o_rdout_word", o_rdout_word, exp_header(n));
      end
      check_val("o_rdout_last", o_rdout_last, 1'b0);
      in_wvf = 1;
      cur_n = n;
      cur_idx = 0;
      cur_len = PRE_LEN + plen_log[n];
      obs_next = n + cur_len + 2;
      if (sw_log[n]) begin
        n_sw++;
      end else begin
        n_thr++;
      end
    end else begin
      // pre samples first, then post samples
      check_val("o_rdout_word", o_rdout_word,
                {1'b0, 19'd0, samp_at(cur_n - PRE_LEN + cur_idx)});
      cur_idx++;
      check_val("o_rdout_last", o_rdout_last, cur_idx == cur_len);
      if (cur_idx == cur_len) begin
        in_wvf = 0;
      end
    end
  endtask

  // each edge closes one local-time cycle
  always @(posedge lclk) begin
    if (!lclk_rst) begin
      log_cycle();
      watch_output();
      t_now++;
    end
    cycle_cnt++;
    if (cycle_cnt > timeout_cyc) begin
      fail_run("timeout, the run did not end within its cycle limit");
    end
  end

  // sw_mode 0 none, 1 sparse, 2 forced
  // ready_mode 0 stall, 1 high, 2 random
  task automatic drive_cycle(bit en, int sw_mode, int ready_mode);
    int step;
    // pull toward the threshold so crossings stay frequent
    step = int'($urandom_range(0, 160)) - 80 + (2048 - walk) / 16;
    walk = walk + step;
    if (walk < 0) begin
      walk = 0;
    end
    if (walk > 4095) begin
      walk = 4095;
    end
    i_adc_sample <= ADC_W'(walk);
    i_trig_en <= en;
    i_sw_trig <= (sw_mode == 2) || (sw_mode == 1 && $urandom_range(0, 39) == 0);
    if (ready_mode == 2) begin
      i_rdout_ready <= 1'($urandom_range(0, 1));
    end else begin
      i_rdout_ready <= (ready_mode == 1);
    end
    @(posedge lclk);
  endtask

  // quiet gap lets a running capture end before the config moves
  task automatic run_phase(int n_cyc, bit en, int ready_mode);
    repeat (gap_len) drive_cycle(1'b0, 0, ready_mode);
    i_post_len <= POST_LEN_W'($urandom_range(1, 31));
    repeat (n_cyc) drive_cycle(en, 1, ready_mode);
  endtask

  initial begin
    void'($urandom(80055));
    walk = 2048;
    timeout_cyc = 3 + 5 * gap_len + 500;
    foreach (phase_len[i]) begin
      timeout_cyc += phase_len[i];
    end
    lclk_rst = 1'b1;
    i_adc_sample = '0;
    i_thresh = 12'd2048;
    i_trig_en = 1'b0;
    i_sw_trig = 1'b0;
    i_post_len = POST_LEN_W'($urandom_range(1, 31));
    i_rdout_ready = 1'b1;
    exact_mode = 1'b1;
    repeat (3) @(posedge lclk);
    lclk_rst <= 1'b0;
    // quiet time 0, then a software trigger at time 1 reaches back before time 0
    drive_cycle(1'b0, 0, 1);
    drive_cycle(1'b1, 2, 1);
    repeat (phase_len[0] - 2) drive_cycle(1'b1, 1, 1);
    // threshold trigger disabled
    run_phase(phase_len[1], 1'b0, 1);
    exact_mode <= 1'b0;
    run_phase(phase_len[2], 1'b1, 2);
    // long stall fills the buffer and starves credits
    run_phase(phase_len[3], 1'b1, 0);
    run_phase(phase_len[4], 1'b1, 1);
    repeat (gap_len) drive_cycle(1'b0, 0, 1);
    while (quiet_cnt < 16 || in_wvf) begin
      drive_cycle(1'b0, 0, 1);
    end
    if (pred_q.size() != 0 || n_sw == 0 || n_thr == 0) begin
      fail_run($sformatf("%0d predicted waveforms never came out, %0d sw and %0d threshold seen",
                         pred_q.size(), n_sw, n_thr));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/wvf_acq_chk.sv
// concurrent checks on the producer credit counter
// and on the readout stream while it is stalled
`default_nettype none

module wvf_acq_chk
  import wvf_pkg::*;
(
  input logic                lclk,
  input logic                lclk_rst,
  input logic                i_wr_en,
  input logic [CREDIT_W-1:0] i_credit_cnt,
  input logic                i_rdout_valid,
  input logic                i_rdout_ready,
  input logic [WORD_W-1:0]   i_rdout_word,
  input logic                i_rdout_last
);

  // credits never exceed the buffer size
  a_credit_max: assert property (@(posedge lclk) disable iff (lclk_rst)
    i_credit_cnt <= CREDIT_W'(BUF_DEPTH))
    else $error("credit count above buffer depth");

  // every write spends a credit that is actually held
  a_write_credit: assert property (@(posedge lclk) disable iff (lclk_rst)
    i_wr_en |-> (i_credit_cnt != '0))
    else $error("buffer write with no credit left");

  // stalled word and last flag stay put
  a_stall_hold: assert property (@(posedge lclk) disable iff (lclk_rst)
    (i_rdout_valid && !i_rdout_ready) |=>
      (i_rdout_valid && $stable(i_rdout_word) && $stable(i_rdout_last)))
    else $error("readout word changed while stalled");

endmodule

// credit counter is taken from inside the capture stage
bind wvf_acq_top wvf_acq_chk u_chk (
  .lclk          (lclk),
  .lclk_rst      (lclk_rst),
  .i_wr_en       (wr_en),
  .i_credit_cnt  (u_capture.credit_cnt),
  .i_rdout_valid (o_rdout_valid),
  .i_rdout_ready (i_rdout_ready),
  .i_rdout_word  (o_rdout_word),
  .i_rdout_last  (o_rdout_last)
);

`default_nettype wire

// File: filelist.f
design/wvf_pkg.sv
design/trig_capture.sv
design/wvf_buffer.sv
design/rdout_framer.sv
design/wvf_acq_top.sv
dv/wvf_acq_chk.sv
dv/tb_wvf_acq.sv
